// ==== design/cpuPkg.sv ====
package cpuPkg;

	// ----------------------------------------
	// Widths and basic words
	// ----------------------------------------
	localparam int unsigned wordWidth = 32;
	localparam int unsigned regAddrWidth = 5;

	typedef logic [wordWidth-1:0] word_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;

	localparam word_t resetVector = '0;

	// ----------------------------------------
	// Opcode and funct codes
	// ----------------------------------------
	localparam logic [5:0] opR = 6'h00;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opSlti = 6'h0a;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opJ = 6'h02;

	localparam logic [5:0] functAdd = 6'h20;
	localparam logic [5:0] functSub = 6'h22;
	localparam logic [5:0] functAnd = 6'h24;
	localparam logic [5:0] functSlt = 6'h2a;
	localparam logic [5:0] functBreak = 6'h0d;

	// ----------------------------------------
	// ALU and instruction word
	// ----------------------------------------
	typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluSlt} aluOp_t;

	typedef struct packed {
		logic zero;
		logic lessThan;
	} aluFlags_t;

	typedef struct packed {
		logic [5:0] opcode;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields_t;

	typedef struct packed {
		logic [5:0] opcode;
		regAddr_t rs;
		regAddr_t rt;
		logic [15:0] imm16;
	} iFields_t;

	typedef union packed {
		rFields_t rFields;
		iFields_t iFields; // Low 26 bits double as jump target
	} instrWord_t;

	// ----------------------------------------
	// Datapath steering
	// ----------------------------------------
	typedef enum logic {srcAPc, srcARegA} srcA_t;
	typedef enum logic [1:0] {srcBRegB, srcBFour, srcBImm, srcBImmShift} srcB_t;
	typedef enum logic [1:0] {pcAluResult, pcAluOut, pcJump} pcSrc_t;
	typedef enum logic [2:0] {wbAluOut, wbMdr, wbUpperImm, wbOne, wbZero} wbSrc_t;
	typedef enum logic {addrPc, addrAluOut} addrSrc_t;

	typedef struct packed {
		logic pcWrite;
		logic irWrite;
		logic aWrite;
		logic bWrite;
		logic aluOutWrite;
		logic mdrWrite;
		logic regWrite;
		logic regDstRd; // Rd for R-type, else rt
		aluOp_t aluOp;
		srcA_t srcA;
		srcB_t srcB;
		pcSrc_t pcSrc;
		wbSrc_t wbSrc;
		addrSrc_t addrSrc;
	} ctrlSignals_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		word_t adr;
		word_t datW;
	} wbRequest_t;

	typedef enum logic [4:0] {
		stReset, stFetch, stDecode, stAluR, stAluI, stWriteR, stWriteI, stLui,
		stJump, stBranch, stMemAddr, stMemRead, stMemWrite, stLoadWrite, stHalt
	} state_t;

endpackage

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
	input cpuPkg::word_t a,
	input cpuPkg::word_t b,
	input cpuPkg::aluOp_t op,
	output cpuPkg::word_t result,
	output cpuPkg::aluFlags_t flags
);

	logic lessThan;

	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			cpuPkg::aluAdd: result = a + b; // Wraps, no overflow trap
			cpuPkg::aluSub: result = a - b;
			cpuPkg::aluAnd: result = a & b;
			cpuPkg::aluSlt: result = {{(cpuPkg::wordWidth-1){1'b0}}, lessThan};
			default: result = a + b;
		endcase
	end

	assign flags.zero = result == '0;
	assign flags.lessThan = lessThan; // Signed compare of the operands

endmodule

// ==== design/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input logic clock,
	input logic reset,
	input cpuPkg::regAddr_t readAddrA,
	input cpuPkg::regAddr_t readAddrB,
	input cpuPkg::regAddr_t writeAddr,
	input logic writeEnable,
	input cpuPkg::word_t writeData,
	output cpuPkg::word_t readDataA,
	output cpuPkg::word_t readDataB
);

	localparam int unsigned regCount = 2 ** cpuPkg::regAddrWidth;

	cpuPkg::word_t regs [regCount];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && writeAddr != '0) begin // $zero stays zero
			regs[writeAddr] <= writeData;
		end
	end

	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

// ==== design/dataPath.sv ====
`timescale 1ns/1ps

module dataPath (
	input logic clock,
	input logic reset,
	input cpuPkg::ctrlSignals_t control,
	input cpuPkg::word_t datR,
	output cpuPkg::instrWord_t instr,
	output cpuPkg::aluFlags_t flags,
	output cpuPkg::word_t adr,
	output cpuPkg::word_t datW
);

	cpuPkg::word_t pc;
	cpuPkg::instrWord_t ir;
	cpuPkg::word_t regA;
	cpuPkg::word_t regB;
	cpuPkg::word_t aluOut;
	cpuPkg::word_t mdr;

	cpuPkg::word_t readDataA;
	cpuPkg::word_t readDataB;
	cpuPkg::word_t aluA;
	cpuPkg::word_t aluB;
	cpuPkg::word_t aluResult;
	cpuPkg::word_t nextPc;
	cpuPkg::word_t writeData;
	cpuPkg::regAddr_t writeAddr;

	cpuPkg::word_t immExt;
	cpuPkg::word_t immShift;
	cpuPkg::word_t upperImm;
	cpuPkg::word_t jumpTarget;

	// ----------------------------------------
	// Architectural registers
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= cpuPkg::resetVector;
		end else if (control.pcWrite) begin
			pc <= nextPc;
		end
	end

	always_ff @(posedge clock) begin
		if (control.irWrite) ir <= datR;
		if (control.mdrWrite) mdr <= datR;
		if (control.aWrite) regA <= readDataA;
		if (control.bWrite) regB <= readDataB;
		if (control.aluOutWrite) aluOut <= aluResult;
	end

	// ----------------------------------------
	// Immediates and muxes
	// ----------------------------------------
	assign immExt = {{16{ir.iFields.imm16[15]}}, ir.iFields.imm16};
	assign immShift = immExt << 2;
	assign upperImm = {ir.iFields.imm16, 16'h0000};
	assign jumpTarget = {pc[31:28], ir.iFields.rs, ir.iFields.rt, ir.iFields.imm16, 2'b00};

	assign aluA = (control.srcA == cpuPkg::srcAPc) ? pc : regA;

	always_comb begin
		case (control.srcB)
			cpuPkg::srcBRegB: aluB = regB;
			cpuPkg::srcBFour: aluB = 32'd4;
			cpuPkg::srcBImm: aluB = immExt;
			default: aluB = immShift; // Branch offset
		endcase
	end

	always_comb begin
		case (control.pcSrc)
			cpuPkg::pcAluResult: nextPc = aluResult;
			cpuPkg::pcAluOut: nextPc = aluOut;
			default: nextPc = jumpTarget;
		endcase
	end

	always_comb begin
		case (control.wbSrc)
			cpuPkg::wbAluOut: writeData = aluOut;
			cpuPkg::wbMdr: writeData = mdr;
			cpuPkg::wbUpperImm: writeData = upperImm;
			cpuPkg::wbOne: writeData = 32'd1;
			default: writeData = '0;
		endcase
	end

	assign writeAddr = control.regDstRd ? ir.rFields.rd : ir.iFields.rt;

	alu aluInst (
		.a(aluA),
		.b(aluB),
		.op(control.aluOp),
		.result(aluResult),
		.flags(flags)
	);

	registerFile regFile (
		.clock(clock),
		.reset(reset),
		.readAddrA(ir.iFields.rs),
		.readAddrB(ir.iFields.rt),
		.writeAddr(writeAddr),
		.writeEnable(control.regWrite),
		.writeData(writeData),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	assign instr = ir;
	assign adr = (control.addrSrc == cpuPkg::addrPc) ? pc : aluOut;
	assign datW = regB;

endmodule

// ==== design/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
	input logic clock,
	input logic reset,
	input cpuPkg::instrWord_t instr,
	input cpuPkg::aluFlags_t flags,
	input logic ack,
	output cpuPkg::ctrlSignals_t control,
	output logic cyc,
	output logic stb,
	output logic we,
	output logic halted
);

	cpuPkg::state_t state;
	cpuPkg::state_t nextState;
	cpuPkg::aluOp_t execOp;
	logic busState;
	logic ackSeen;
	logic ackTaken;
	logic isSlt;

	function automatic cpuPkg::aluOp_t aluOpFor(input cpuPkg::instrWord_t i);
		cpuPkg::aluOp_t op;
		op = cpuPkg::aluAdd;
		if (i.rFields.opcode == cpuPkg::opR) begin
			case (i.rFields.funct)
				cpuPkg::functSub: op = cpuPkg::aluSub;
				cpuPkg::functAnd: op = cpuPkg::aluAnd;
				cpuPkg::functSlt: op = cpuPkg::aluSlt;
				default: op = cpuPkg::aluAdd;
			endcase
		end else if (i.iFields.opcode == cpuPkg::opSlti) begin
			op = cpuPkg::aluSlt;
		end
		return op;
	endfunction

	assign execOp = aluOpFor(instr);
	assign isSlt = execOp == cpuPkg::aluSlt;

	// ----------------------------------------
	// Wishbone strobes
	// ----------------------------------------
	assign busState = state == cpuPkg::stFetch || state == cpuPkg::stMemRead
		|| state == cpuPkg::stMemWrite;
	assign cyc = busState && !ackSeen; // Gap cycle after every ack
	assign stb = cyc;
	assign we = cyc && state == cpuPkg::stMemWrite;
	assign ackTaken = stb && ack;
	assign halted = state == cpuPkg::stHalt;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= cpuPkg::stReset;
			ackSeen <= 1'b0;
		end else begin
			state <= nextState;
			ackSeen <= ackTaken;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			cpuPkg::stReset: nextState = cpuPkg::stFetch;
			cpuPkg::stFetch: if (ackTaken) nextState = cpuPkg::stDecode;
			cpuPkg::stDecode: begin
				case (instr.rFields.opcode)
					cpuPkg::opR: begin
						case (instr.rFields.funct)
							cpuPkg::functAdd, cpuPkg::functSub, cpuPkg::functAnd,
							cpuPkg::functSlt: nextState = cpuPkg::stAluR;
							default: nextState = cpuPkg::stHalt; // Break and unknown funct
						endcase
					end
					cpuPkg::opAddi, cpuPkg::opAddiu, cpuPkg::opSlti: nextState = cpuPkg::stAluI;
					cpuPkg::opLui: nextState = cpuPkg::stLui;
					cpuPkg::opLw, cpuPkg::opSw: nextState = cpuPkg::stMemAddr;
					cpuPkg::opBeq, cpuPkg::opBne: nextState = cpuPkg::stBranch;
					cpuPkg::opJ: nextState = cpuPkg::stJump;
					default: nextState = cpuPkg::stHalt;
				endcase
			end
			cpuPkg::stAluR: nextState = cpuPkg::stWriteR;
			cpuPkg::stAluI: nextState = cpuPkg::stWriteI;
			cpuPkg::stMemAddr: begin
				if (instr.iFields.opcode == cpuPkg::opLw) nextState = cpuPkg::stMemRead;
				else nextState = cpuPkg::stMemWrite;
			end
			cpuPkg::stMemRead: if (ackTaken) nextState = cpuPkg::stLoadWrite;
			cpuPkg::stMemWrite: if (ackTaken) nextState = cpuPkg::stFetch;
			cpuPkg::stHalt: nextState = cpuPkg::stHalt; // Until reset
			default: nextState = cpuPkg::stFetch;
		endcase
	end

	// ----------------------------------------
	// Control word per state
	// ----------------------------------------
	always_comb begin
		control = '0;
		case (state)
			cpuPkg::stFetch: begin
				control.srcB = cpuPkg::srcBFour;
				control.pcWrite = ackTaken;
				control.irWrite = ackTaken;
			end
			cpuPkg::stDecode: begin
				control.aWrite = 1'b1;
				control.bWrite = 1'b1;
				control.srcB = cpuPkg::srcBImmShift; // Branch target into ALUOut
				control.aluOutWrite = 1'b1;
			end
			cpuPkg::stAluR, cpuPkg::stAluI, cpuPkg::stWriteR, cpuPkg::stWriteI: begin
				control.srcA = cpuPkg::srcARegA;
				control.aluOp = execOp;
				if (state == cpuPkg::stAluR || state == cpuPkg::stWriteR) begin
					control.srcB = cpuPkg::srcBRegB;
				end else begin
					control.srcB = cpuPkg::srcBImm;
				end
				if (state == cpuPkg::stAluR || state == cpuPkg::stAluI) begin
					control.aluOutWrite = 1'b1;
				end else begin
					control.regWrite = 1'b1;
					control.regDstRd = state == cpuPkg::stWriteR;
					if (isSlt) control.wbSrc = flags.lessThan ? cpuPkg::wbOne : cpuPkg::wbZero;
					else control.wbSrc = cpuPkg::wbAluOut;
				end
			end
			cpuPkg::stLui: begin
				control.regWrite = 1'b1;
				control.wbSrc = cpuPkg::wbUpperImm;
			end
			cpuPkg::stJump: begin
				control.pcWrite = 1'b1;
				control.pcSrc = cpuPkg::pcJump;
			end
			cpuPkg::stBranch: begin
				control.srcA = cpuPkg::srcARegA;
				control.srcB = cpuPkg::srcBRegB;
				control.aluOp = cpuPkg::aluSub;
				control.pcSrc = cpuPkg::pcAluOut;
				if (instr.iFields.opcode == cpuPkg::opBeq) control.pcWrite = flags.zero;
				else control.pcWrite = !flags.zero;
			end
			cpuPkg::stMemAddr: begin
				control.srcA = cpuPkg::srcARegA;
				control.srcB = cpuPkg::srcBImm;
				control.aluOutWrite = 1'b1;
			end
			cpuPkg::stMemRead: begin
				control.addrSrc = cpuPkg::addrAluOut;
				control.mdrWrite = ackTaken;
			end
			cpuPkg::stMemWrite: control.addrSrc = cpuPkg::addrAluOut;
			cpuPkg::stLoadWrite: begin
				control.regWrite = 1'b1;
				control.wbSrc = cpuPkg::wbMdr;
			end
			default: control = '0;
		endcase
	end

endmodule

// ==== design/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop (
	input logic clock,
	input logic reset,
	output cpuPkg::wbRequest_t bus,
	input logic ack,
	input cpuPkg::word_t datR,
	output logic halted
);

	cpuPkg::ctrlSignals_t control;
	cpuPkg::instrWord_t instr;
	cpuPkg::aluFlags_t flags;

	controlUnit ctrl (
		.clock(clock),
		.reset(reset),
		.instr(instr),
		.flags(flags),
		.ack(ack),
		.control(control),
		.cyc(bus.cyc),
		.stb(bus.stb),
		.we(bus.we),
		.halted(halted)
	);

	dataPath path (
		.clock(clock),
		.reset(reset),
		.control(control),
		.datR(datR),
		.instr(instr),
		.flags(flags),
		.adr(bus.adr),
		.datW(bus.datW)
	);

endmodule

// ==== tests/wishbone_asserts.sv ====
`timescale 1ns/1ps

module wishboneAsserts (
	input logic clock,
	input logic reset,
	input cpuPkg::wbRequest_t bus,
	input logic ack,
	input logic halted
);

	// ----------------------------------------
	// Handshake rules
	// ----------------------------------------
	stbWithCyc: assert property (@(posedge clock) disable iff (reset) bus.stb |-> bus.cyc)
		else $error("stb high without cyc");

	requestHeld: assert property (@(posedge clock) disable iff (reset)
		bus.stb && !ack |=> $stable(bus.adr) && $stable(bus.we) && $stable(bus.datW))
		else $error("Request changed while waiting for ack");

	gapAfterAck: assert property (@(posedge clock) disable iff (reset) bus.stb && ack |=> !bus.cyc)
		else $error("cyc still high in the cycle after ack");

	quietWhenHalted: assert property (@(posedge clock) disable iff (reset) halted |-> !bus.stb)
		else $error("Strobe raised while halted");

endmodule

bind cpuTop wishboneAsserts busChecks (
	.clock(clock),
	.reset(reset),
	.bus(bus),
	.ack(ack),
	.halted(halted)
);

// ==== tests/cpuTestbench.sv ====
`timescale 1ns/1ps

module cpuTestbench;

	typedef enum int {refAdd, refSub, refAnd, refSlt, refLui} refOp_t;

	localparam int memWords = 256;
	localparam int haltTimeout = 3000; // Cycles
	localparam int quietCycles = 20;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic ack = 1'b0;
	cpuPkg::word_t datR = '0;
	cpuPkg::wbRequest_t bus;
	logic halted;

	cpuPkg::word_t mem [memWords];
	cpuPkg::word_t expAddr [$];
	cpuPkg::word_t expData [$];
	cpuPkg::word_t skipAddr [$];
	integer seed = 66689;
	int valueErrors = 0;
	int otherErrors = 0;
	int progIndex = 0;
	logic pending = 1'b0;
	int waitLeft = 0;

	cpuTop uut (
		.clock(clock),
		.reset(reset),
		.bus(bus),
		.ack(ack),
		.datR(datR),
		.halted(halted)
	);

	initial begin
		forever begin
			#20 clock = ~clock;
		end
	end

	function automatic cpuPkg::word_t expectedResult(input refOp_t op, input cpuPkg::word_t a,
		input cpuPkg::word_t b);
		cpuPkg::word_t r;
		case (op)
			refAdd: r = a + b; // Wraps on overflow
			refSub: r = a - b;
			refAnd: r = a & b;
			refSlt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: r = {b[15:0], 16'h0000};
		endcase
		return r;
	endfunction

	function automatic cpuPkg::word_t signExtend(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic cpuPkg::instrWord_t rTypeWord(input logic [5:0] funct, input int rs,
		input int rt, input int rd);
		cpuPkg::instrWord_t w;
		w.rFields.opcode = cpuPkg::opR;
		w.rFields.rs = cpuPkg::regAddr_t'(rs);
		w.rFields.rt = cpuPkg::regAddr_t'(rt);
		w.rFields.rd = cpuPkg::regAddr_t'(rd);
		w.rFields.shamt = '0;
		w.rFields.funct = funct;
		return w;
	endfunction

	function automatic cpuPkg::instrWord_t iTypeWord(input logic [5:0] op, input int rs,
		input int rt, input logic [15:0] imm);
		cpuPkg::instrWord_t w;
		w.iFields.opcode = op;
		w.iFields.rs = cpuPkg::regAddr_t'(rs);
		w.iFields.rt = cpuPkg::regAddr_t'(rt);
		w.iFields.imm16 = imm;
		return w;
	endfunction

	function automatic cpuPkg::instrWord_t jumpWord(input int target);
		cpuPkg::instrWord_t w;
		w = '0;
		w.iFields.opcode = cpuPkg::opJ;
		w[25:0] = 26'(target >> 2); // Word index of the target
		return w;
	endfunction

	task automatic placeWord(input cpuPkg::instrWord_t w);
		mem[progIndex] = w;
		progIndex++;
	endtask

	task automatic storeChecked(input int rt, input logic [15:0] addr, input cpuPkg::word_t data);
		placeWord(iTypeWord(cpuPkg::opSw, 0, rt, addr));
		expAddr.push_back({16'h0000, addr});
		expData.push_back(data);
	endtask

	task automatic storeSkipped(input int rt, input logic [15:0] addr);
		placeWord(iTypeWord(cpuPkg::opSw, 0, rt, addr));
		skipAddr.push_back({16'h0000, addr});
	endtask

	// ----------------------------------------
	// Program and data image
	// ----------------------------------------
	task automatic loadProgram();
		cpuPkg::word_t a;
		cpuPkg::word_t b;
		cpuPkg::word_t big;
		cpuPkg::word_t low;
		logic [15:0] immAddi;
		logic [15:0] immAddiu;
		logic [15:0] immSlti;
		logic [15:0] immLui;
		for (int i = 0; i < memWords; i++) begin
			mem[i] = 32'hbad00000 | cpuPkg::word_t'(i * 4);
		end
		a = $random(seed);
		b = $random(seed);
		if (b == a) begin
			b = a + 32'd1; // Keep the unequal branch cases unequal
		end
		mem[128] = a;
		mem[129] = b;
		mem[130] = a;
		immAddi = 16'($random(seed));
		immAddiu = 16'($random(seed));
		immSlti = 16'($random(seed));
		immLui = 16'($random(seed));
		big = expectedResult(refLui, '0, 32'h7fff);
		low = expectedResult(refLui, '0, 32'h8000);
		placeWord(iTypeWord(cpuPkg::opLw, 0, 1, 16'h0200));
		placeWord(iTypeWord(cpuPkg::opLw, 0, 2, 16'h0204));
		placeWord(iTypeWord(cpuPkg::opLw, 0, 3, 16'h0208));
		placeWord(rTypeWord(cpuPkg::functAdd, 1, 2, 4));
		storeChecked(4, 16'h0300, expectedResult(refAdd, a, b));
		placeWord(rTypeWord(cpuPkg::functSub, 1, 2, 5));
		storeChecked(5, 16'h0304, expectedResult(refSub, a, b));
		placeWord(rTypeWord(cpuPkg::functAnd, 1, 2, 6));
		storeChecked(6, 16'h0308, expectedResult(refAnd, a, b));
		placeWord(rTypeWord(cpuPkg::functSlt, 1, 2, 7));
		storeChecked(7, 16'h030c, expectedResult(refSlt, a, b));
		placeWord(rTypeWord(cpuPkg::functSlt, 2, 1, 7));
		storeChecked(7, 16'h0310, expectedResult(refSlt, b, a));
		placeWord(iTypeWord(cpuPkg::opAddi, 1, 8, immAddi));
		storeChecked(8, 16'h0314, expectedResult(refAdd, a, signExtend(immAddi)));
		placeWord(iTypeWord(cpuPkg::opAddiu, 2, 9, immAddiu));
		storeChecked(9, 16'h0318, expectedResult(refAdd, b, signExtend(immAddiu)));
		placeWord(iTypeWord(cpuPkg::opSlti, 1, 10, immSlti));
		storeChecked(10, 16'h031c, expectedResult(refSlt, a, signExtend(immSlti)));
		placeWord(iTypeWord(cpuPkg::opLui, 0, 11, immLui));
		storeChecked(11, 16'h0320, expectedResult(refLui, '0, {16'h0000, immLui}));
		placeWord(iTypeWord(cpuPkg::opLui, 0, 12, 16'h7fff));
		placeWord(rTypeWord(cpuPkg::functAdd, 12, 12, 13));
		storeChecked(13, 16'h0324, expectedResult(refAdd, big, big)); // Signed overflow
		placeWord(iTypeWord(cpuPkg::opLui, 0, 15, 16'h8000));
		placeWord(iTypeWord(cpuPkg::opAddi, 15, 16, 16'hffff));
		storeChecked(16, 16'h0328, expectedResult(refAdd, low, signExtend(16'hffff)));
		// Branches skip one store when taken
		placeWord(iTypeWord(cpuPkg::opBeq, 1, 3, 16'd1));
		storeSkipped(1, 16'h032c);
		storeChecked(2, 16'h0330, b);
		placeWord(iTypeWord(cpuPkg::opBeq, 1, 2, 16'd1));
		storeChecked(1, 16'h0334, a);
		placeWord(iTypeWord(cpuPkg::opBne, 1, 2, 16'd1));
		storeSkipped(1, 16'h033c);
		storeChecked(2, 16'h0340, b);
		placeWord(iTypeWord(cpuPkg::opBne, 1, 3, 16'd1));
		storeChecked(3, 16'h0344, a);
		placeWord(jumpWord((progIndex + 2) * 4));
		storeSkipped(1, 16'h0348);
		storeChecked(1, 16'h034c, a);
		placeWord(rTypeWord(cpuPkg::functBreak, 0, 0, 0));
		storeSkipped(1, 16'h0350); // Never reached
	endtask

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic checkWord(input cpuPkg::word_t actual, input cpuPkg::word_t expected,
		input string what);
		if (actual !== expected) begin
			$display("Fail %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			valueErrors++;
		end
	endtask

	task automatic checkAddress(input cpuPkg::word_t actual, input cpuPkg::word_t expected,
		input string what);
		if (actual !== expected) begin
			$display("Fail %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			valueErrors++;
		end
	endtask

	task automatic checkHalt(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("Fail %0t ns: %s is %b, expected %b", $time, what, actual, expected);
			valueErrors++;
		end
	endtask

	task automatic waitForHalt(output logic done);
		for (int n = 0; n < haltTimeout && halted !== 1'b1; n++) begin
			@(posedge clock);
		end
		done = halted === 1'b1;
		if (!done) begin
			$display("Timed out at %0t ns waiting for the CPU to halt", $time);
			otherErrors++;
		end
	endtask

	// Slave with 0 to 3 wait cycles per request
	always @(posedge clock) begin : wishboneSlave
		int delay;
		logic [7:0] index;
		index = bus.adr[9:2];
		delay = 0;
		if (reset) begin
			ack <= 1'b0;
			pending <= 1'b0;
		end else if (ack) begin
			ack <= 1'b0;
			pending <= 1'b0;
		end else if (bus.cyc && bus.stb) begin
			if (!pending) delay = $random(seed) & 3;
			else delay = waitLeft;
			if (delay == 0) begin
				ack <= 1'b1;
				if (bus.we) mem[index] <= bus.datW;
				else datR <= mem[index];
			end else begin
				pending <= 1'b1;
				waitLeft <= delay - 1;
			end
		end
	end

	always @(posedge clock) begin : storeMonitor
		cpuPkg::word_t wantAddr;
		cpuPkg::word_t wantData;
		if (!reset && bus.cyc && bus.stb && bus.we && ack) begin
			foreach (skipAddr[i]) begin
				if (bus.adr == skipAddr[i]) begin
					$display("A skipped store reached address %h at %0t ns", bus.adr, $time);
					otherErrors++;
				end
			end
			if (expAddr.size() == 0) begin
				$display("Unexpected store to %h at %0t ns", bus.adr, $time);
				otherErrors++;
			end else begin
				wantAddr = expAddr.pop_front();
				wantData = expData.pop_front();
				checkAddress(bus.adr, wantAddr, "store address");
				checkWord(bus.datW, wantData, $sformatf("store data at %h", wantAddr));
			end
		end
	end

	initial begin
		logic done;
		loadProgram();
		repeat (2) @(posedge clock);
		checkHalt(halted, 1'b0, "halted during reset");
		if (bus.cyc !== 1'b0) begin
			$display("A bus cycle was active during reset");
			otherErrors++;
		end
		reset <= 1'b0;
		@(posedge clock);
		checkHalt(halted, 1'b0, "halted after reset");
		if (bus.cyc !== 1'b0) begin
			$display("A bus cycle started before the first fetch");
			otherErrors++;
		end
		@(posedge clock);
		if (bus.cyc !== 1'b1) begin
			$display("The first fetch did not start after reset");
			otherErrors++;
		end
		checkAddress(bus.adr, cpuPkg::resetVector, "first fetch address");
		waitForHalt(done);
		if (done) begin
			repeat (quietCycles) @(posedge clock);
			checkHalt(halted, 1'b1, "halted after break");
			if (expAddr.size() != 0) begin
				$display("%0d expected stores never appeared", expAddr.size());
				otherErrors++;
			end
		end
		$display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
design/cpuPkg.sv
design/alu.sv
design/registerFile.sv
design/dataPath.sv
design/controlUnit.sv
design/cpuTop.sv
tests/wishbone_asserts.sv
tests/cpuTestbench.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = cpuTestbench
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
